/* verilog/clock_pkg.sv */
// --------------------------------------------------
// Shared widths, encodings, limits and the
// seven-segment table of the hour:minute:second clock
// --------------------------------------------------
package clock_pkg;

	// Operating mode, stepped by the mode button
	typedef enum logic [1:0] {
		MODE_CLOCK = 2'd0,
		MODE_SETUP = 2'd1,
		MODE_ALARM = 2'd2
	} mode_t;

	// Field selected for setting
	typedef enum logic [1:0] {
		POS_SEC  = 2'd0,
		POS_MIN  = 2'd1,
		POS_HOUR = 2'd2
	} pos_t;

	localparam int FIELD_W = 6;
	typedef logic [FIELD_W-1:0] field_t;

	localparam field_t SEC_MAX  = 6'd59;
	localparam field_t MIN_MAX  = 6'd59;
	localparam field_t HOUR_MAX = 6'd23;

	localparam int NUM_DIGITS = 6;
	typedef logic [2:0] digit_sel_t;	// Scan index 0..5

	typedef logic [6:0] seg_t;	// Bit 6 = a ... bit 0 = g
	localparam seg_t SEG_BLANK = 7'b000_0000;

	// Decimal points per mode, bit 0 is the rightmost digit
	localparam logic [NUM_DIGITS-1:0] DP_CLOCK = 6'b010101;
	localparam logic [NUM_DIGITS-1:0] DP_SETUP = 6'b000001;
	localparam logic [NUM_DIGITS-1:0] DP_ALARM = 6'b000010;

	// --------------------------------------------------
	// BCD digit to segments, anything above 9 is blank
	// --------------------------------------------------
	function automatic seg_t seg_decode(input logic [3:0] digit);
		case (digit)
			4'd0:    return 7'b111_1110;
			4'd1:    return 7'b011_0000;
			4'd2:    return 7'b110_1101;
			4'd3:    return 7'b111_1001;
			4'd4:    return 7'b011_0011;
			4'd5:    return 7'b101_1011;
			4'd6:    return 7'b101_1111;
			4'd7:    return 7'b111_0000;
			4'd8:    return 7'b111_1111;
			4'd9:    return 7'b111_0011;
			default: return SEG_BLANK;
		endcase
	endfunction

endpackage

/* verilog/tick_gen.sv */
// --------------------------------------------------
// Free-running dividers for the second, blink,
// scan and button sample strobes
// --------------------------------------------------
module tick_gen #(
	parameter int unsigned SEC_DIV    = 50_000_000,
	parameter int unsigned SCAN_DIV   = 5_000,
	parameter int unsigned SAMPLE_DIV = 500_000
) (
	input  logic clk,
	input  logic rst_n,
	output logic o_sec_tick,
	output logic o_blink_on,
	output logic o_scan_tick,
	output logic o_sample_tick
);

	localparam int SEC_W    = $clog2(SEC_DIV + 1);
	localparam int SCAN_W   = $clog2(SCAN_DIV + 1);
	localparam int SAMPLE_W = $clog2(SAMPLE_DIV + 1);

	logic [SEC_W-1:0]    sec_cnt;
	logic [SCAN_W-1:0]   scan_cnt;
	logic [SAMPLE_W-1:0] sample_cnt;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			sec_cnt       <= '0;
			scan_cnt      <= '0;
			sample_cnt    <= '0;
			o_sec_tick    <= 1'b0;
			o_scan_tick   <= 1'b0;
			o_sample_tick <= 1'b0;
		end else begin
			o_sec_tick    <= (sec_cnt == SEC_W'(SEC_DIV - 1));
			o_scan_tick   <= (scan_cnt == SCAN_W'(SCAN_DIV - 1));
			o_sample_tick <= (sample_cnt == SAMPLE_W'(SAMPLE_DIV - 1));
			sec_cnt    <= (sec_cnt == SEC_W'(SEC_DIV - 1)) ? '0 : sec_cnt + 1'b1;	// SEC_DIV states
			scan_cnt   <= (scan_cnt == SCAN_W'(SCAN_DIV - 1)) ? '0 : scan_cnt + 1'b1;
			sample_cnt <= (sample_cnt == SAMPLE_W'(SAMPLE_DIV - 1)) ? '0 : sample_cnt + 1'b1;
		end
	end

	// Second half of each second period
	assign o_blink_on = (sec_cnt >= SEC_W'(SEC_DIV / 2));

endmodule

/* verilog/button_sync.sv */
// --------------------------------------------------
// Button sampling and falling-edge press pulses
// --------------------------------------------------
module button_sync (
	input  logic       clk,
	input  logic       rst_n,
	input  logic       i_sample_tick,
	input  logic [3:0] i_btn,	// Bit 0 mode, 1 pos, 2 inc, 3 alarm
	output logic [3:0] o_press
);

	logic [3:0] btn_meta;
	logic [3:0] btn_sync;
	logic [3:0] hist_new;	// Sample from the last strobe

	// Buttons idle high
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			btn_meta <= '1;
			btn_sync <= '1;
			hist_new <= '1;
		end else begin
			btn_meta <= i_btn;
			btn_sync <= btn_meta;
			if (i_sample_tick)
				hist_new <= btn_sync;
		end
	end

	// One pulse per high to low step between samples
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			o_press <= '0;
		end else begin
			o_press <= i_sample_tick ? (~btn_sync & hist_new) : '0;
		end
	end

endmodule

/* verilog/clock_ctrl.sv */
// --------------------------------------------------
// Mode, position and alarm enable registers with
// routing of the second tick and increment presses
// --------------------------------------------------
module clock_ctrl
	import clock_pkg::*;
(
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic [3:0]            i_press,	// Bit 0 mode, 1 pos, 2 inc, 3 alarm
	input  logic                  i_sec_tick,
	output mode_t                 o_mode,
	output pos_t                  o_pos,
	output logic                  o_alarm_en,
	output logic                  o_time_tick,
	output logic [NUM_DIGITS-1:0] o_dp,
	output logic [2:0]            o_time_inc,	// Bit 0 sec, 1 min, 2 hour
	output logic [2:0]            o_alarm_inc
);

	logic       press_mode;
	logic       press_pos;
	logic       press_inc;
	logic       press_alarm;
	logic [2:0] field_sel;

	assign {press_alarm, press_inc, press_pos, press_mode} = i_press;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			o_mode     <= MODE_CLOCK;
			o_pos      <= POS_SEC;
			o_alarm_en <= 1'b0;
		end else begin
			if (press_mode) begin
				case (o_mode)
					MODE_CLOCK: o_mode <= MODE_SETUP;
					MODE_SETUP: o_mode <= MODE_ALARM;
					default:    o_mode <= MODE_CLOCK;
				endcase
			end
			if (press_pos) begin
				case (o_pos)
					POS_SEC: o_pos <= POS_MIN;
					POS_MIN: o_pos <= POS_HOUR;
					default: o_pos <= POS_SEC;
				endcase
			end
			if (press_alarm)
				o_alarm_en <= ~o_alarm_en;
		end
	end

	// --------------------------------------------------
	// Strobe routing
	// --------------------------------------------------
	assign field_sel   = 3'b001 << o_pos;
	assign o_time_tick = i_sec_tick && (o_mode != MODE_SETUP);	// Clock stops in setup
	assign o_time_inc  = (press_inc && o_mode == MODE_SETUP) ? field_sel : 3'b000;
	assign o_alarm_inc = (press_inc && o_mode == MODE_ALARM) ? field_sel : 3'b000;

	always_comb begin
		case (o_mode)
			MODE_SETUP: o_dp = DP_SETUP;
			MODE_ALARM: o_dp = DP_ALARM;
			default:    o_dp = DP_CLOCK;
		endcase
	end

endmodule

/* verilog/hms_counter.sv */
// --------------------------------------------------
// Hours/minutes/seconds counter, carry on tick and
// single-field step on increment
// --------------------------------------------------
module hms_counter
	import clock_pkg::*;
(
	input  logic       clk,
	input  logic       rst_n,
	input  logic       i_tick,
	input  logic [2:0] i_inc,	// Bit 0 sec, 1 min, 2 hour
	output field_t     o_sec,
	output field_t     o_min,
	output field_t     o_hour
);

	logic sec_wrap;
	logic min_wrap;

	// Step with wrap at the field's own maximum
	function automatic field_t next_field(input field_t val, input field_t max_val);
		return (val == max_val) ? '0 : val + 1'b1;
	endfunction

	assign sec_wrap = (o_sec == SEC_MAX);
	assign min_wrap = (o_min == MIN_MAX);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			o_sec  <= '0;
			o_min  <= '0;
			o_hour <= '0;
		end else if (i_tick) begin
			o_sec <= next_field(o_sec, SEC_MAX);
			if (sec_wrap) begin
				o_min <= next_field(o_min, MIN_MAX);
				if (min_wrap)
					o_hour <= next_field(o_hour, HOUR_MAX);	// 23:59:59 -> 00:00:00
			end
		end else begin
			// No carry between fields here
			if (i_inc[0])
				o_sec <= next_field(o_sec, SEC_MAX);
			if (i_inc[1])
				o_min <= next_field(o_min, MIN_MAX);
			if (i_inc[2])
				o_hour <= next_field(o_hour, HOUR_MAX);
		end
	end

endmodule

/* verilog/time_keeper.sv */
// --------------------------------------------------
// Time and alarm counters, display source select
// and the alarm flag
// --------------------------------------------------
module time_keeper
	import clock_pkg::*;
(
	input  logic       clk,
	input  logic       rst_n,
	input  mode_t      i_mode,
	input  logic       i_alarm_en,
	input  logic       i_time_tick,
	input  logic [2:0] i_time_inc,
	input  logic [2:0] i_alarm_inc,
	output field_t     o_sec,
	output field_t     o_min,
	output field_t     o_hour,
	output logic       o_alarm
);

	field_t time_sec;
	field_t time_min;
	field_t time_hour;
	field_t alarm_sec;
	field_t alarm_min;
	field_t alarm_hour;
	logic   time_match;

	hms_counter u_time (
		.clk    (clk),
		.rst_n  (rst_n),
		.i_tick (i_time_tick),
		.i_inc  (i_time_inc),
		.o_sec  (time_sec),
		.o_min  (time_min),
		.o_hour (time_hour)
	);

	// Alarm time only moves by the increment button
	hms_counter u_alarm_time (
		.clk    (clk),
		.rst_n  (rst_n),
		.i_tick (1'b0),
		.i_inc  (i_alarm_inc),
		.o_sec  (alarm_sec),
		.o_min  (alarm_min),
		.o_hour (alarm_hour)
	);

	always_comb begin
		if (i_mode == MODE_ALARM) begin
			o_sec  = alarm_sec;
			o_min  = alarm_min;
			o_hour = alarm_hour;
		end else begin
			o_sec  = time_sec;
			o_min  = time_min;
			o_hour = time_hour;
		end
	end

	assign time_match = (time_sec == alarm_sec) && (time_min == alarm_min) &&
		(time_hour == alarm_hour);

	// Flag sticks until the enable is toggled off
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			o_alarm <= 1'b0;
		else
			o_alarm <= i_alarm_en && (o_alarm || time_match);
	end

endmodule

/* verilog/seg_display.sv */
// --------------------------------------------------
// Digit split, segment decode, blink blanking and
// the six-digit scan multiplexer
// --------------------------------------------------
module seg_display
	import clock_pkg::*;
(
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  i_scan_tick,
	input  logic                  i_blink_on,
	input  mode_t                 i_mode,
	input  pos_t                  i_pos,
	input  logic [NUM_DIGITS-1:0] i_dp,
	input  field_t                i_sec,
	input  field_t                i_min,
	input  field_t                i_hour,
	output seg_t                  o_seg,
	output logic                  o_seg_dp,
	output logic [NUM_DIGITS-1:0] o_seg_enb
);

	localparam int NUM_FIELDS = NUM_DIGITS / 2;

	digit_sel_t scan_idx;
	field_t     field_val [NUM_FIELDS];
	seg_t       digit_seg [NUM_DIGITS];	// Index 0 is the rightmost digit
	logic       blink_off;

	// --------------------------------------------------
	// Scan index
	// --------------------------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			scan_idx <= '0;
		end else if (i_scan_tick) begin
			if (scan_idx == digit_sel_t'(NUM_DIGITS - 1))
				scan_idx <= '0;
			else
				scan_idx <= scan_idx + 1'b1;
		end
	end

	// --------------------------------------------------
	// Per-field decode
	// --------------------------------------------------
	assign field_val[0] = i_sec;
	assign field_val[1] = i_min;
	assign field_val[2] = i_hour;

	// Dark phase of the blink in the setting modes
	assign blink_off = !i_blink_on && (i_mode == MODE_SETUP || i_mode == MODE_ALARM);

	for (genvar f = 0; f < NUM_FIELDS; f++) begin : g_field
		logic [3:0] tens;
		logic [3:0] units;
		logic       blank;

		assign tens  = 4'(field_val[f] / 10);
		assign units = 4'(field_val[f] % 10);
		assign blank = blink_off && (i_pos == pos_t'(f));

		assign digit_seg[2*f]   = blank ? SEG_BLANK : seg_decode(units);
		assign digit_seg[2*f+1] = blank ? SEG_BLANK : seg_decode(tens);
	end

	// --------------------------------------------------
	// Output mux
	// --------------------------------------------------
	assign o_seg     = digit_seg[scan_idx];
	assign o_seg_dp  = i_dp[scan_idx];
	assign o_seg_enb = ~(NUM_DIGITS'(1) << scan_idx);	// Active low, one-hot

endmodule

/* verilog/digital_clock_top.sv */
// --------------------------------------------------
// Top level of the hour:minute:second clock
// --------------------------------------------------
module digital_clock_top
	import clock_pkg::*;
#(
	parameter int unsigned SEC_DIV    = 50_000_000,
	parameter int unsigned SCAN_DIV   = 5_000,
	parameter int unsigned SAMPLE_DIV = 500_000
) (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  i_btn_mode,
	input  logic                  i_btn_pos,
	input  logic                  i_btn_inc,
	input  logic                  i_btn_alarm,
	output seg_t                  o_seg,
	output logic                  o_seg_dp,
	output logic [NUM_DIGITS-1:0] o_seg_enb,
	output logic                  o_alarm
);

	logic                  sec_tick;
	logic                  blink_on;
	logic                  scan_tick;
	logic                  sample_tick;
	logic [3:0]            press;
	mode_t                 mode;
	pos_t                  pos;
	logic                  alarm_en;
	logic                  time_tick;
	logic [NUM_DIGITS-1:0] dp;
	logic [2:0]            time_inc;
	logic [2:0]            alarm_inc;
	field_t                disp_sec;
	field_t                disp_min;
	field_t                disp_hour;

	tick_gen #(
		.SEC_DIV    (SEC_DIV),
		.SCAN_DIV   (SCAN_DIV),
		.SAMPLE_DIV (SAMPLE_DIV)
	) u_tick_gen (
		.clk           (clk),
		.rst_n         (rst_n),
		.o_sec_tick    (sec_tick),
		.o_blink_on    (blink_on),
		.o_scan_tick   (scan_tick),
		.o_sample_tick (sample_tick)
	);

	button_sync u_button_sync (
		.clk           (clk),
		.rst_n         (rst_n),
		.i_sample_tick (sample_tick),
		.i_btn         ({i_btn_alarm, i_btn_inc, i_btn_pos, i_btn_mode}),
		.o_press       (press)
	);

	clock_ctrl u_clock_ctrl (
		.clk         (clk),
		.rst_n       (rst_n),
		.i_press     (press),
		.i_sec_tick  (sec_tick),
		.o_mode      (mode),
		.o_pos       (pos),
		.o_alarm_en  (alarm_en),
		.o_time_tick (time_tick),
		.o_dp        (dp),
		.o_time_inc  (time_inc),
		.o_alarm_inc (alarm_inc)
	);

	time_keeper u_time_keeper (
		.clk         (clk),
		.rst_n       (rst_n),
		.i_mode      (mode),
		.i_alarm_en  (alarm_en),
		.i_time_tick (time_tick),
		.i_time_inc  (time_inc),
		.i_alarm_inc (alarm_inc),
		.o_sec       (disp_sec),
		.o_min       (disp_min),
		.o_hour      (disp_hour),
		.o_alarm     (o_alarm)
	);

	seg_display u_seg_display (
		.clk         (clk),
		.rst_n       (rst_n),
		.i_scan_tick (scan_tick),
		.i_blink_on  (blink_on),
		.i_mode      (mode),
		.i_pos       (pos),
		.i_dp        (dp),
		.i_sec       (disp_sec),
		.i_min       (disp_min),
		.i_hour      (disp_hour),
		.o_seg       (o_seg),
		.o_seg_dp    (o_seg_dp),
		.o_seg_enb   (o_seg_enb)
	);

endmodule

/* bench/digital_clock_tb.sv */
// --------------------------------------------------
// Testbench for the hour:minute:second clock with
// display capture and directed tests
// --------------------------------------------------
module digital_clock_tb
	import clock_pkg::*;
();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int SEC_DIV     = 400;
	localparam int SCAN_DIV    = 4;
	localparam int SAMPLE_DIV  = 8;
	localparam int DAY_SECS    = 24 * 60 * 60;
	localparam int SCAN_LIMIT  = 4 * NUM_DIGITS * SCAN_DIV;
	localparam int READ_TRIES  = 30;
	localparam int SYNC_TRIES  = 40;
	localparam int ALARM_TRIES = 2000;
	localparam int INC_PRESSES = 62;	// More than one full minute wrap
	localparam int BTN_MODE    = 0;
	localparam int BTN_POS     = 1;
	localparam int BTN_INC     = 2;
	localparam int BTN_ALARM   = 3;

	logic                  clk;
	logic                  rst_n;
	logic [3:0]            btn;	// Mode, pos, inc, alarm from bit 0
	seg_t                  seg;
	logic                  seg_dp;
	logic [NUM_DIGITS-1:0] seg_enb;
	logic                  alarm;

	string                   test_name;
	int                      checks = 0;
	int                      errors = 0;
	int                      timeouts = 0;
	logic [NUM_DIGITS*7-1:0] scan_segs;	// Last captured scan, index 0 at the bottom
	logic [NUM_DIGITS-1:0]   scan_dp;
	logic                    scan_ok;
	int                      rd_time;	// Seconds since midnight
	logic [NUM_DIGITS-1:0]   rd_dp;
	logic                    rd_ok;
	int                      exp_time;

	digital_clock_top #(
		.SEC_DIV    (SEC_DIV),
		.SCAN_DIV   (SCAN_DIV),
		.SAMPLE_DIV (SAMPLE_DIV)
	) digital_clock_top_inst (
		.clk         (clk),
		.rst_n       (rst_n),
		.i_btn_mode  (btn[BTN_MODE]),
		.i_btn_pos   (btn[BTN_POS]),
		.i_btn_inc   (btn[BTN_INC]),
		.i_btn_alarm (btn[BTN_ALARM]),
		.o_seg       (seg),
		.o_seg_dp    (seg_dp),
		.o_seg_enb   (seg_enb),
		.o_alarm     (alarm)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// --------------------------------------------------
	// Helpers
	// --------------------------------------------------
	// Segment pattern back to a digit, -1 when blank or unknown
	function automatic int seg_to_digit(input seg_t pattern);
		for (int d = 0; d < 10; d++)
			if (seg_decode(4'(d)) == pattern)
				return d;
		return -1;
	endfunction

	function automatic int enb_index(input logic [NUM_DIGITS-1:0] enb);
		for (int i = 0; i < NUM_DIGITS; i++)
			if (enb == ~(NUM_DIGITS'(1) << i))
				return i;
		return -1;
	endfunction

	// Readable hhmmss form for error lines
	function automatic int to_hms(input int t);
		return (t / 3600) * 10000 + ((t / 60) % 60) * 100 + t % 60;
	endfunction

	task automatic note_failure(input string msg);
		errors++;
		$display("Test %s: %s", test_name, msg);
	endtask

	task automatic note_timeout(input string msg);
		timeouts++;
		$display("Timeout in test %s: %s", test_name, msg);
	endtask

	task automatic check_value(input string what, input int expected, input int actual);
		checks++;
		assert (actual == expected) else begin
			errors++;
			$display("error %s %s: expected %0d, actual %0d", test_name, what, expected,
				actual);
		end
	endtask

	task automatic press_button(input int which);
		@(posedge clk);
		btn[which] <= 1'b0;
		repeat (4 * SAMPLE_DIV) @(posedge clk);
		btn[which] <= 1'b1;
		repeat (4 * SAMPLE_DIV) @(posedge clk);
	endtask

	// --------------------------------------------------
	// Display capture
	// --------------------------------------------------
	task automatic sample_index(output int idx);
		@(negedge clk);
		idx = enb_index(seg_enb);
		assert (idx >= 0) else
			note_failure($sformatf("digit enables %b are not one-hot active low", seg_enb));
	endtask

	// One scan from the entry into index 0 to the next one
	task automatic capture_scan();
		int   idx;
		int   cur;
		int   cnt;
		logic done;
		scan_ok = 1'b0;
		cnt = 0;
		done = 1'b0;
		sample_index(idx);
		while (idx == 0 && cnt < SCAN_LIMIT) begin
			sample_index(idx);
			cnt++;
		end
		while (idx != 0 && cnt < SCAN_LIMIT) begin
			sample_index(idx);
			cnt++;
		end
		cur = 0;
		scan_segs[6:0] = seg;
		scan_dp[0] = seg_dp;
		while (!done && cnt < SCAN_LIMIT) begin
			sample_index(idx);
			cnt++;
			if (idx != cur) begin
				assert (idx == (cur + 1) % NUM_DIGITS) else
					note_failure($sformatf("scan jumped from digit %0d to %0d", cur, idx));
				cur = idx;
				if (idx == 0) begin
					done = 1'b1;
				end else if (idx > 0) begin
					scan_segs[idx*7 +: 7] = seg;
					scan_dp[idx] = seg_dp;
				end
			end
		end
		if (done)
			scan_ok = 1'b1;
		else
			note_timeout("no complete display scan");
	endtask

	// Two equal scans with six readable digits
	task automatic read_display();
		logic [NUM_DIGITS*7-1:0] prev_segs;
		logic [NUM_DIGITS-1:0]   prev_dp;
		int                      tries;
		int                      digit [NUM_DIGITS];
		logic                    readable;
		rd_ok = 1'b0;
		tries = 0;
		capture_scan();
		while (!rd_ok && tries < READ_TRIES) begin
			prev_segs = scan_segs;
			prev_dp = scan_dp;
			capture_scan();
			readable = scan_ok;
			for (int i = 0; i < NUM_DIGITS; i++) begin
				digit[i] = seg_to_digit(scan_segs[i*7 +: 7]);
				if (digit[i] < 0)
					readable = 1'b0;
			end
			rd_ok = readable && scan_segs == prev_segs && scan_dp == prev_dp;
			tries++;
		end
		if (!rd_ok)
			note_timeout("display did not settle on a readable time");
		rd_time = (digit[5] * 10 + digit[4]) * 3600 + (digit[3] * 10 + digit[2]) * 60 +
			digit[1] * 10 + digit[0];
		rd_dp = scan_dp;
	endtask

	// Returns just after the displayed second changes
	task automatic sync_to_tick();
		int t0;
		int tries;
		read_display();
		t0 = rd_time;
		tries = 0;
		while (rd_time == t0 && tries < SYNC_TRIES) begin
			read_display();
			tries++;
		end
		if (rd_time == t0)
			note_timeout("time did not advance");
	endtask

	// --------------------------------------------------
	// Directed tests
	// --------------------------------------------------
	task automatic test_reset();
		test_name = "reset";
		check_value("alarm flag", 0, alarm);
		read_display();
		check_value("time", 0, to_hms(rd_time));
		check_value("decimal points", DP_CLOCK, rd_dp);
	endtask

	task automatic test_timekeeping();
		int t0;
		test_name = "timekeeping";
		sync_to_tick();
		t0 = rd_time;
		repeat (65 * SEC_DIV) @(posedge clk);	// Seconds wrap into the minutes
		read_display();
		check_value("time after 65 s", to_hms((t0 + 65) % DAY_SECS), to_hms(rd_time));
		sync_to_tick();
		t0 = rd_time;
		repeat (3600 * SEC_DIV) @(posedge clk);	// Minutes wrap into the hours
		read_display();
		check_value("time after 3600 s", to_hms((t0 + 3600) % DAY_SECS), to_hms(rd_time));
	endtask

	task automatic test_setup();
		int t0;
		test_name = "setup";
		press_button(BTN_MODE);
		read_display();
		check_value("decimal points", DP_SETUP, rd_dp);
		t0 = rd_time;
		press_button(BTN_POS);
		repeat (INC_PRESSES) press_button(BTN_INC);
		// Minutes wrap on their own, no carry into the hours
		exp_time = (t0 / 3600) * 3600 + (((t0 / 60) % 60 + INC_PRESSES) % 60) * 60 + t0 % 60;
		read_display();
		check_value("time after minute steps", to_hms(exp_time), to_hms(rd_time));
		repeat (3 * SEC_DIV) @(posedge clk);
		read_display();
		check_value("time while stopped", to_hms(exp_time), to_hms(rd_time));
	endtask

	task automatic test_blink();
		int idx;
		int digit;
		int want_min;
		int seen_blank;
		int seen_value;
		int wrong_value;
		int other_blank;
		test_name = "blink";
		want_min = (exp_time / 60) % 60;
		seen_blank = 0;
		seen_value = 0;
		wrong_value = 0;
		other_blank = 0;
		repeat (SEC_DIV + 2 * NUM_DIGITS * SCAN_DIV) begin
			sample_index(idx);
			digit = seg_to_digit(seg);
			if (idx == 2 || idx == 3) begin
				if (seg == SEG_BLANK)
					seen_blank++;
				else if (digit == ((idx == 2) ? want_min % 10 : want_min / 10))
					seen_value++;
				else
					wrong_value++;
			end else if (seg == SEG_BLANK) begin
				other_blank++;
			end
		end
		check_value("minute digits seen blank", 1, seen_blank > 0);
		check_value("minute digits seen lit", 1, seen_value > 0);
		check_value("wrong minute digit samples", 0, wrong_value);
		check_value("blank samples on other digits", 0, other_blank);
	endtask

	task automatic test_alarm();
		int t0;
		int target;
		int tries;
		int drops;
		test_name = "alarm";
		// Clear the seconds while the clock is stopped
		press_button(BTN_POS);
		press_button(BTN_POS);
		repeat ((60 - exp_time % 60) % 60) press_button(BTN_INC);
		press_button(BTN_POS);
		t0 = exp_time - exp_time % 60;
		read_display();
		check_value("time with seconds cleared", to_hms(t0), to_hms(rd_time));
		press_button(BTN_MODE);
		read_display();
		check_value("alarm time after reset", 0, to_hms(rd_time));
		check_value("decimal points", DP_ALARM, rd_dp);
		target = (t0 + 60) % DAY_SECS;
		repeat ((target / 60) % 60) press_button(BTN_INC);
		press_button(BTN_POS);
		repeat (target / 3600) press_button(BTN_INC);
		read_display();
		check_value("alarm time set", to_hms(target), to_hms(rd_time));
		press_button(BTN_ALARM);
		press_button(BTN_MODE);
		tries = 0;
		read_display();
		while (rd_time != target && tries < ALARM_TRIES) begin
			check_value("flag before alarm time", 0, alarm);
			read_display();
			tries++;
		end
		if (rd_time != target)
			note_timeout("display never reached the alarm time");
		check_value("flag at alarm time", 1, alarm);
		drops = 0;
		repeat (2 * SEC_DIV) begin
			@(negedge clk);
			if (!alarm)
				drops++;
		end
		check_value("cycles with flag dropped", 0, drops);
		press_button(BTN_ALARM);
		@(negedge clk);
		check_value("flag after disable", 0, alarm);
	endtask

	// --------------------------------------------------
	// Sequence
	// --------------------------------------------------
	initial begin
		rst_n = 1'b0;
		btn = 4'b1111;	// Released
		repeat (4) @(posedge clk);
		rst_n <= 1'b1;
		@(posedge clk);
		test_reset();
		test_timekeeping();
		test_setup();
		test_blink();
		test_alarm();
		$display("Checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
		if (errors == 0 && timeouts == 0) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	end

endmodule

/* filelist.f */
verilog/clock_pkg.sv
verilog/tick_gen.sv
verilog/button_sync.sv
verilog/clock_ctrl.sv
verilog/hms_counter.sv
verilog/time_keeper.sv
verilog/seg_display.sv
verilog/digital_clock_top.sv
bench/digital_clock_tb.sv

/* Bender.yml */
package:
  name: digital_clock

sources:
  - files:
      - verilog/clock_pkg.sv
      - verilog/tick_gen.sv
      - verilog/button_sync.sv
      - verilog/clock_ctrl.sv
      - verilog/hms_counter.sv
      - verilog/time_keeper.sv
      - verilog/seg_display.sv
      - verilog/digital_clock_top.sv
  - target: simulation
    files:
      - bench/digital_clock_tb.sv
